// File: Makefile
TB_TOP = tb_wb_apb
RTL_TOP = wb_apb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(RTL_TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f verilog.f -o sim_$(TB_TOP)
	out=$$(./obj_dir/sim_$(TB_TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: apb_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module apb_monitor #(
	parameter int max_stall = 4
) (
	input wire PCLK,
	input wire rst,
	input wire PSEL,
	input wire PENABLE,
	input wire PREADY,
	input wire PWRITE,
	input wire PSLVERR,
	input wire apb_pkg::addr_t PADDR,
	input wire apb_pkg::data_t PWDATA,
	input wire apb_pkg::strb_t PWSTRB,
	output logic prot_err
);
	import apb_pkg::*;

	localparam int cnt_w = $clog2(max_stall + 1);
	localparam logic [cnt_w-1:0] stall_lim = cnt_w'(max_stall);

	// Low in the first cycle after reset
	logic armed;
	logic p_sel;
	logic p_enable;
	logic p_ready;
	logic p_write;
	addr_t p_addr;
	data_t p_wdata;
	strb_t p_strb;
	logic stalled;
	logic violation;
	logic [cnt_w-1:0] stall_cnt;

	////////////////////
	// Previous cycle
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			armed <= 1'b0;
			p_sel <= 1'b0;
			p_enable <= 1'b0;
			p_ready <= 1'b0;
		end
		else
		begin
			armed <= 1'b1;
			p_sel <= PSEL;
			p_enable <= PENABLE;
			p_ready <= PREADY;
		end
		p_write <= PWRITE;
		p_addr <= PADDR;
		p_wdata <= PWDATA;
		p_strb <= PWSTRB;
	end

	// Last cycle was setup or a waiting access
	assign stalled = p_sel && !(p_enable && p_ready);

	// Saturating count of access cycles with PREADY low
	always_ff @(posedge PCLK)
	begin
		if (rst || !PSEL || !PENABLE)
			stall_cnt <= '0;
		else if (!PREADY && stall_cnt < stall_lim)
			stall_cnt <= stall_cnt + 1'b1;
	end

	////////////////////
	// Rule checks
	////////////////////

	always_comb
	begin
		violation = 1'b0;
		if (!armed)
			violation = PSEL;
		else
		begin
			// Setup carries no PENABLE
			if (PSEL && !p_sel && PENABLE)
				violation = 1'b1;
			// Setup is followed by access
			if (p_sel && !p_enable && !(PSEL && PENABLE))
				violation = 1'b1;
			// Access repeats until ready, then PENABLE drops
			if (p_sel && p_enable && PSEL && (PENABLE == p_ready))
				violation = 1'b1;
			if (stalled && !PSEL)
				violation = 1'b1;
			if (stalled && (PADDR != p_addr || PWRITE != p_write))
				violation = 1'b1;
			if (stalled && PWRITE && (PWDATA != p_wdata || PWSTRB != p_strb))
				violation = 1'b1;
		end
		if (stall_cnt >= stall_lim)
			violation = 1'b1;
		// Error only at completion
		if (PSLVERR && !(PSEL && PENABLE && PREADY))
			violation = 1'b1;
	end

	// Sticky until reset
	always_ff @(posedge PCLK)
	begin
		if (rst)
			prot_err <= 1'b0;
		else if (violation)
			prot_err <= 1'b1;
	end

	// Bus idle in the first cycle after reset
	a_reset_idle: assert property (@(posedge PCLK) $fell(rst) |-> !PSEL);
	a_setup: assert property (@(posedge PCLK) disable iff (rst) $rose(PSEL) |-> !PENABLE);
	a_access: assert property (@(posedge PCLK) disable iff (rst)
		PSEL && !PENABLE |=> PSEL && PENABLE);
	// PENABLE held while stalled and dropped once PREADY was seen
	a_en_hold: assert property (@(posedge PCLK) disable iff (rst)
		PSEL && PENABLE |=> !PSEL || (PENABLE == !$past(PREADY)));
	a_hold: assert property (@(posedge PCLK) disable iff (rst)
		PSEL && !(PENABLE && PREADY) |=> PSEL && $stable(PADDR) && $stable(PWRITE));
	a_wdata: assert property (@(posedge PCLK) disable iff (rst)
		PSEL && !(PENABLE && PREADY) && PWRITE |=> $stable(PWDATA) && $stable(PWSTRB));
	a_stall: assert property (@(posedge PCLK) disable iff (rst) stall_cnt < stall_lim);
	a_slverr: assert property (@(posedge PCLK) disable iff (rst)
		PSLVERR |-> PSEL && PENABLE && PREADY);

endmodule

`default_nettype wire

// File: apb_pkg.sv
`default_nettype none

// APB bus geometry shared by the bridge, the register block and the monitor
package apb_pkg;

	////////////////////
	// Widths
	////////////////////

	// Byte address covering the register window
	localparam int addr_w = 8;
	// Data path width
	localparam int data_w = 32;
	// One strobe per data byte
	localparam int strb_w = data_w / 8;

	////////////////////
	// Vector types
	////////////////////

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;
	typedef logic [strb_w-1:0] strb_t;

endpackage

`default_nettype wire

// File: apb_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module apb_regfile #(
	parameter int n_regs = 8
) (
	input wire PCLK,
	input wire rst,
	input wire PSEL,
	input wire PENABLE,
	input wire PWRITE,
	input wire apb_pkg::addr_t PADDR,
	input wire apb_pkg::data_t PWDATA,
	input wire apb_pkg::strb_t PWSTRB,
	output logic PREADY,
	output logic PSLVERR,
	output apb_pkg::data_t PRDATA
);
	import apb_pkg::*;
	import regs_pkg::*;

	int idx;
	logic access_ph;
	logic mapped;
	logic bad;
	wait_t wait_q;
	wait_t wait_cnt;
	data_t scratch0;
	data_t scratch1;

	// Byte-lane merge under strobes
	function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
		data_t res;
		res = old_val;
		for (int i = 0; i < strb_w; i++)
			if (strb[i])
				res[8*i +: 8] = new_val[8*i +: 8];
		return res;
	endfunction

	////////////////////
	// Decode
	////////////////////

	assign idx = int'(PADDR[addr_w-1:2]);
	assign access_ph = PSEL && PENABLE;

	always_comb
	begin
		case (idx)
			reg_wait, reg_scratch0, reg_scratch1, reg_id:
				mapped = (idx < n_regs);
			default:
				mapped = 1'b0;
		endcase
	end

	// Misaligned, unmapped, or write to the ID register
	assign bad = (PADDR[1:0] != 2'b00) || !mapped || (PWRITE && idx == reg_id);

	// Wait states counted inside the access phase
	always_ff @(posedge PCLK)
	begin
		if (rst)
			wait_cnt <= '0;
		else if (access_ph && !PREADY)
			wait_cnt <= wait_cnt + 1'b1;
		else
			wait_cnt <= '0;
	end

	assign PREADY = access_ph && (wait_cnt == wait_q);
	assign PSLVERR = PREADY && bad;

	// Read mux with errored reads returning zero
	always_comb
	begin
		PRDATA = '0;
		if (!bad)
			case (idx)
				reg_wait: PRDATA = data_t'(wait_q);
				reg_scratch0: PRDATA = scratch0;
				reg_scratch1: PRDATA = scratch1;
				reg_id: PRDATA = id_value;
				default: PRDATA = '0;
			endcase
	end

	////////////////////
	// Register writes
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			wait_q <= '0;
			scratch0 <= '0;
			scratch1 <= '0;
		end
		else if (PREADY && PWRITE && !bad)
			case (idx)
				// Only the low field bits are kept
				reg_wait: wait_q <= wait_t'(merge_bytes(data_t'(wait_q), PWDATA, PWSTRB));
				reg_scratch0: scratch0 <= merge_bytes(scratch0, PWDATA, PWSTRB);
				reg_scratch1: scratch1 <= merge_bytes(scratch1, PWDATA, PWSTRB);
				default: ;
			endcase
	end

	a_err_ready: assert property (@(posedge PCLK) disable iff (rst) PSLVERR |-> PREADY);

endmodule

`default_nettype wire

// File: apb_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module apb_sequencer (
	input wire PCLK,
	input wire rst,
	input wire req_valid,
	input wire req_write,
	input wire apb_pkg::addr_t req_addr,
	input wire apb_pkg::data_t req_wdata,
	input wire apb_pkg::strb_t req_strb,
	output logic req_done,
	output logic req_err,
	output apb_pkg::data_t req_rdata,
	output logic PSEL,
	output logic PENABLE,
	output logic PWRITE,
	output apb_pkg::addr_t PADDR,
	output apb_pkg::data_t PWDATA,
	output apb_pkg::strb_t PWSTRB,
	input wire PREADY,
	input wire PSLVERR,
	input wire apb_pkg::data_t PRDATA
);
	import apb_pkg::*;

	typedef enum logic [1:0] {idle, setup, access} state_t;

	state_t state;
	logic launch;
	addr_t addr_q;
	data_t wdata_q;
	strb_t strb_q;
	logic write_q;

	// Skip the cycle of the done pulse while the front still holds req_valid
	assign launch = (state == idle) && req_valid && !req_done;

	////////////////////
	// APB master FSM
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			state <= idle;
			req_done <= 1'b0;
		end
		else
		begin
			req_done <= 1'b0;
			case (state)
				idle:
					if (launch)
						state <= setup;
				setup:
					state <= access;
				// Stay here while the slave stalls
				access:
					if (PREADY)
					begin
						state <= idle;
						req_done <= 1'b1;
					end
				default:
					state <= idle;
			endcase
		end
	end

	// Bus fields frozen for the whole transfer
	always_ff @(posedge PCLK)
	begin
		if (launch)
		begin
			addr_q <= req_addr;
			write_q <= req_write;
			wdata_q <= req_wdata;
			// Reads carry no strobes
			strb_q <= req_write ? req_strb : '0;
		end
		// Completion result back to the front
		if (state == access && PREADY)
		begin
			req_rdata <= PRDATA;
			req_err <= PSLVERR;
		end
	end

	assign PSEL = (state != idle);
	assign PENABLE = (state == access);
	assign PADDR = addr_q;
	assign PWRITE = write_q;
	assign PWDATA = wdata_q;
	assign PWSTRB = strb_q;

	a_en_sel: assert property (@(posedge PCLK) disable iff (rst) PENABLE |-> PSEL);

endmodule

`default_nettype wire

// File: regs_pkg.sv
`default_nettype none

// Register map of the APB register block
package regs_pkg;

	// Word indices, byte address is index times four
	localparam int reg_wait = 0;
	localparam int reg_scratch0 = 1;
	localparam int reg_scratch1 = 2;
	localparam int reg_id = 7;

	// Value returned by the read-only ID register
	localparam logic [31:0] id_value = 32'h5742_4150;

	// Wait-state field in reg_wait
	localparam int wait_w = 2;
	typedef logic [wait_w-1:0] wait_t;

endpackage

`default_nettype wire

// File: tb_wb_apb.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wb_apb;
	import apb_pkg::*;
	import regs_pkg::*;

	// Request count of all tests below, sets the run limit
	localparam int n_requests = 45;
	localparam int cycle_limit = 60 * n_requests + 20;
	// Sampling edge to response, with the slowest wait setting
	localparam int max_latency = 7;

	logic PCLK;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	addr_t wb_adr;
	data_t wb_dat_w;
	strb_t wb_sel;
	data_t wb_dat_r;
	logic wb_ack;
	logic wb_err;
	logic prot_err;

	// Register map model
	wait_t model_wait;
	data_t model_scratch0;
	data_t model_scratch1;

	logic [15:0] lfsr;
	int cycle_cnt = 0;
	int req_cnt = 0;

	wb_apb_top #(.max_stall(4), .n_regs(8)) wb_apb_top_inst (.*);

	initial PCLK = 1'b0;
	always #50 PCLK = ~PCLK;

	////////////////////
	// Failure handling
	////////////////////

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped after a failed check");
	endtask

	task automatic fail_value(input string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	// Run limit, counts every clock including reset
	always @(posedge PCLK)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("Timeout after %0d cycles: no Wishbone response arrived", cycle_cnt);
			abort_run();
		end
	end

	////////////////////
	// Random source
	////////////////////

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One LFSR step per bit shifted in
	task automatic random_bits(input int n, output data_t v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[data_w-2:0], lfsr[0]};
		end
	endtask

	function automatic addr_t word_addr(input int idx);
		return addr_t'(idx * 4);
	endfunction

	////////////////////
	// Reference model
	////////////////////

	// Full byte for every strobe bit set
	function automatic data_t lane_mask(input strb_t sel);
		data_t m;
		int b;
		m = '0;
		for (b = 0; b < strb_w; b++)
			m[8*b +: 8] = {8{sel[b]}};
		return m;
	endfunction

	// Expected response, updates the model on good writes
	task automatic predict(input logic we, input addr_t adr, input data_t dat,
		input strb_t sel, output logic exp_err, output data_t exp_rdata);
		int idx;
		data_t mask;
		data_t old_wait;
		idx = int'(adr) / 4;
		mask = lane_mask(sel);
		old_wait = data_t'(model_wait);
		exp_rdata = '0;
		exp_err = 1'b0;
		if (adr[1:0] != 2'b00)
			exp_err = 1'b1;
		else if (idx != reg_wait && idx != reg_scratch0 && idx != reg_scratch1 && idx != reg_id)
			exp_err = 1'b1;
		// ID is read-only
		else if (we && idx == reg_id)
			exp_err = 1'b1;
		else if (we)
		begin
			if (idx == reg_wait)
				model_wait = wait_t'((old_wait & ~mask) | (dat & mask));
			else if (idx == reg_scratch0)
				model_scratch0 = (model_scratch0 & ~mask) | (dat & mask);
			else
				model_scratch1 = (model_scratch1 & ~mask) | (dat & mask);
		end
		else if (idx == reg_wait)
			exp_rdata = old_wait;
		else if (idx == reg_scratch0)
			exp_rdata = model_scratch0;
		else if (idx == reg_scratch1)
			exp_rdata = model_scratch1;
		else
			exp_rdata = id_value;
	endtask

	////////////////////
	// Wishbone master
	////////////////////

	// One classic cycle, held until ack or err
	task automatic wb_transfer(input logic we, input addr_t adr, input data_t dat,
		input strb_t sel, output data_t rdata, output logic ack, output logic err);
		int latency;
		@(posedge PCLK);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		wb_sel = sel;
		// This edge samples the request
		@(posedge PCLK);
		#1;
		latency = 0;
		while (!wb_ack && !wb_err)
		begin
			@(posedge PCLK);
			#1;
			latency++;
		end
		assert (latency <= max_latency)
			else fail_value($sformatf("response after %0d cycles at 0x%02h", latency, adr));
		assert (wb_ack != wb_err)
			else fail_value("ack and err high together");
		rdata = wb_dat_r;
		ack = wb_ack;
		err = wb_err;
		// Drop the strobe before the next request
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(posedge PCLK);
		#1;
		assert (!wb_ack && !wb_err)
			else fail_value("response lasted more than one cycle");
		assert (!prot_err)
			else fail_value($sformatf("prot_err set after access to 0x%02h", adr));
		req_cnt++;
	endtask

	// Transfer plus comparison against the model
	task automatic checked_access(input logic we, input addr_t adr, input data_t dat,
		input strb_t sel);
		data_t rdata;
		data_t exp_rdata;
		logic ack;
		logic err;
		logic exp_err;
		predict(we, adr, dat, sel, exp_err, exp_rdata);
		wb_transfer(we, adr, dat, sel, rdata, ack, err);
		assert (err == exp_err)
			else fail_value($sformatf("%s 0x%02h err %0b, expected %0b",
				we ? "write" : "read", adr, err, exp_err));
		if (!we)
			assert (rdata == exp_rdata)
				else fail_value($sformatf("read 0x%02h got 0x%08h, expected 0x%08h",
					adr, rdata, exp_rdata));
	endtask

	task automatic write_reg(input addr_t adr, input data_t dat, input strb_t sel);
		checked_access(1'b1, adr, dat, sel);
	endtask

	task automatic read_reg(input addr_t adr);
		checked_access(1'b0, adr, '0, '0);
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial
	begin
		data_t d;
		data_t s;
		int i;
		int w;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		lfsr = 16'd3429;
		model_wait = '0;
		model_scratch0 = '0;
		model_scratch1 = '0;
		repeat (3) @(posedge PCLK);
		#1;
		rst = 1'b0;
		assert (!wb_ack && !wb_err && !prot_err)
			else fail_value("outputs not low after reset");

		// Reset values and ID
		read_reg(word_addr(reg_wait));
		read_reg(word_addr(reg_scratch0));
		read_reg(word_addr(reg_scratch1));
		read_reg(word_addr(reg_id));

		// Random strobes on both scratch registers
		for (i = 0; i < 6; i++)
		begin
			random_bits(data_w, d);
			random_bits(strb_w, s);
			write_reg(word_addr((i % 2 == 0) ? reg_scratch0 : reg_scratch1), d, strb_t'(s));
			read_reg(word_addr((i % 2 == 0) ? reg_scratch0 : reg_scratch1));
		end

		// Each wait setting, upper bits must be dropped
		for (w = 0; w < 4; w++)
		begin
			random_bits(data_w - wait_w, d);
			d = {d[data_w-wait_w-1:0], wait_t'(w)};
			write_reg(word_addr(reg_wait), d, 4'hf);
			read_reg(word_addr(reg_wait));
			random_bits(data_w, d);
			random_bits(strb_w, s);
			write_reg(word_addr(reg_scratch0), d, strb_t'(s));
			read_reg(word_addr(reg_scratch0));
		end

		// Unmapped slots
		for (i = 3; i < 7; i++)
		begin
			random_bits(data_w, d);
			write_reg(word_addr(i), d, 4'hf);
			read_reg(word_addr(i));
		end
		// Read-only ID
		random_bits(data_w, d);
		write_reg(word_addr(reg_id), d, 4'hf);
		read_reg(word_addr(reg_id));
		// Misaligned write and read
		random_bits(data_w, d);
		write_reg(word_addr(reg_scratch0) + addr_t'(1), d, 4'hf);
		read_reg(word_addr(reg_scratch0));
		read_reg(word_addr(reg_scratch1) + addr_t'(2));

		assert (!prot_err)
			else fail_value("protocol monitor flagged a violation");
		if (req_cnt == n_requests)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
		begin
			$display("Only %0d of %0d requests completed", req_cnt, n_requests);
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
apb_pkg.sv
regs_pkg.sv
wb_front.sv
apb_sequencer.sv
apb_regfile.sv
apb_monitor.sv
wb_apb_top.sv
tb_wb_apb.sv

// File: wb_apb_top.sv
`timescale 1ns/1ns
`default_nettype none

module wb_apb_top #(
	parameter int max_stall = 4,
	parameter int n_regs = 8
) (
	input wire PCLK,
	input wire rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire apb_pkg::addr_t wb_adr,
	input wire apb_pkg::data_t wb_dat_w,
	input wire apb_pkg::strb_t wb_sel,
	output apb_pkg::data_t wb_dat_r,
	output logic wb_ack,
	output logic wb_err,
	output logic prot_err
);
	import apb_pkg::*;

	// Front to sequencer request channel
	logic req_valid;
	logic req_write;
	addr_t req_addr;
	data_t req_wdata;
	strb_t req_strb;
	logic req_done;
	logic req_err;
	data_t req_rdata;

	// APB bus
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	addr_t PADDR;
	data_t PWDATA;
	strb_t PWSTRB;
	logic PREADY;
	logic PSLVERR;
	data_t PRDATA;

	wb_front wb_front_inst (.*);

	apb_sequencer apb_sequencer_inst (.*);

	apb_regfile #(.n_regs(n_regs)) apb_regfile_inst (.*);

	// Passive checker on the same bus
	apb_monitor #(.max_stall(max_stall)) apb_monitor_inst (.*);

endmodule

`default_nettype wire

// File: wb_front.sv
`timescale 1ns/1ns
`default_nettype none

module wb_front (
	input wire PCLK,
	input wire rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire apb_pkg::addr_t wb_adr,
	input wire apb_pkg::data_t wb_dat_w,
	input wire apb_pkg::strb_t wb_sel,
	output apb_pkg::data_t wb_dat_r,
	output logic wb_ack,
	output logic wb_err,
	output logic req_valid,
	output logic req_write,
	output apb_pkg::addr_t req_addr,
	output apb_pkg::data_t req_wdata,
	output apb_pkg::strb_t req_strb,
	input wire req_done,
	input wire req_err,
	input wire apb_pkg::data_t req_rdata
);
	import apb_pkg::*;

	typedef enum logic [1:0] {idle, busy, respond} state_t;

	state_t state;
	logic accept;
	logic complete;

	// New request only from idle
	assign accept = (state == idle) && wb_cyc && wb_stb;
	assign complete = (state == busy) && req_done;

	////////////////////
	// Handshake FSM
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			state <= idle;
			req_valid <= 1'b0;
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
		end
		else
		begin
			// Responses are single-cycle pulses
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
			case (state)
				idle:
					if (accept)
					begin
						req_valid <= 1'b1;
						state <= busy;
					end
				busy:
					if (req_done)
					begin
						req_valid <= 1'b0;
						wb_ack <= !req_err;
						wb_err <= req_err;
						state <= respond;
					end
				// Hold off until the master drops stb
				respond:
					if (!wb_stb)
						state <= idle;
				default:
					state <= idle;
			endcase
		end
	end

	// Request fields and read data
	always_ff @(posedge PCLK)
	begin
		if (accept)
		begin
			req_write <= wb_we;
			req_addr <= wb_adr;
			req_wdata <= wb_dat_w;
			req_strb <= wb_sel;
		end
		if (complete)
			wb_dat_r <= req_rdata;
	end

	// Exactly one response kind
	a_one_resp: assert property (@(posedge PCLK) disable iff (rst) !(wb_ack && wb_err));

endmodule

`default_nettype wire
